//--- eth_tx.f
eth_tx_pkg.sv
eth_mac_if.sv
mac_framer.sv
crc32_gen.sv
frame_tx.sv
eth_tx_top.sv
eth_tx_sva.sv
tb_eth_tx.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_eth_tx -f eth_tx.f -o Vtb_eth_tx

./obj_dir/Vtb_eth_tx > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation reported no failure"
exit 0

//--- tb_eth_tx.sv
`timescale 1ns/100ps

module tb_eth_tx import eth_tx_pkg::*; ();

    localparam int BUF_DEPTH      = 64;
    localparam int NUM_FRAMES     = 20;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 250 + 1000;    // Longest frame near 170 cycles

    logic        clk;
    logic        rst;
    logic [47:0] dst_addr;
    logic [47:0] src_addr;
    logic [15:0] eth_type;
    logic        wr_en;
    logic [7:0]  wr_data;
    logic        start;
    logic        ready;
    logic        done;
    logic [7:0]  txd;
    logic        tx_en;

    logic [31:0] rng;
    int          cyc;
    int          err_value;
    int          err_other;
    logic [7:0]  payload_q[$];
    logic [7:0]  body_q[$];     // Header, data and pad
    logic [7:0]  exp_q[$];
    logic [7:0]  got_q[$];

    eth_tx_top #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_eth_tx_top (
        .clk      (clk),
        .rst      (rst),
        .dst_addr (dst_addr),
        .src_addr (src_addr),
        .eth_type (eth_type),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .start    (start),
        .ready    (ready),
        .done     (done),
        .txd      (txd),
        .tx_en    (tx_en)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the frame sequence did not finish", cyc);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic value_error(input string name, input int unsigned exp_v, input int unsigned act_v);
        $display("error: %s expected %0h actual %0h", name, exp_v, act_v);
        err_value++;
    endtask

    task automatic protocol_error(input string what);
        $display("%s", what);
        err_other++;
    endtask

    // Bitwise reflected CRC-32 over the body, LSB of each byte first
    function automatic logic [31:0] fcs_of_body();
        logic [31:0] c;
        logic [7:0]  d;
        logic        fb;
        c = CRC_INIT;
        for (int i = 0; i < body_q.size(); i++) begin
            d = body_q[i];
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ d[0];
                c  = fb ? ((c >> 1) ^ CRC_POLY_REFL) : (c >> 1);
                d  = d >> 1;
            end
        end
        return ~c;
    endfunction

    function automatic string section_of(input int i, input int n);
        int pad_end;
        pad_end = 8 + HDR_BYTES + ((n > MIN_PAYLOAD) ? n : MIN_PAYLOAD);
        if (i < 8) return "preamble";
        if (i < 8 + HDR_BYTES) return "header";
        if (i < 8 + HDR_BYTES + n) return "data";
        return (i < pad_end) ? "pad" : "fcs";
    endfunction

    task automatic build_expected(input int n);
        logic [31:0] fcs;
        body_q.delete();
        exp_q.delete();
        for (int i = 0; i < 6; i++) body_q.push_back(dst_addr[47 - 8*i -: 8]);
        for (int i = 0; i < 6; i++) body_q.push_back(src_addr[47 - 8*i -: 8]);
        body_q.push_back(eth_type[15:8]);
        body_q.push_back(eth_type[7:0]);
        for (int i = 0; i < n; i++) body_q.push_back(payload_q[i]);
        for (int i = n; i < MIN_PAYLOAD; i++) body_q.push_back(8'h00);
        fcs = fcs_of_body();
        for (int i = 0; i < 7; i++) exp_q.push_back(PREAMBLE_BYTE);
        exp_q.push_back(SFD_BYTE);
        for (int i = 0; i < body_q.size(); i++) exp_q.push_back(body_q[i]);
        for (int i = 0; i < 4; i++) exp_q.push_back(fcs[8*i +: 8]);    // Low byte first
    endtask

    task automatic run_frame(input int f);
        int          n;
        int          start_cyc;
        int          first_cyc;
        logic        seen;
        logic [31:0] r1;
        logic [31:0] r2;
        while (!ready) begin
            @(posedge clk);
            #1;
        end
        r1 = next_random();
        r2 = next_random();
        dst_addr = {r1[15:0], r2};
        r1 = next_random();
        r2 = next_random();
        src_addr = {r1[15:0], r2};
        eth_type = r2[31:16] ^ r1[31:16];
        r1 = next_random();
        n = (f == 0) ? 0 : (f == 1) ? BUF_DEPTH : int'(r1 % (BUF_DEPTH + 1));
        payload_q.delete();
        for (int i = 0; i < n; i++) begin
            r1 = next_random();
            payload_q.push_back(r1[7:0]);
            wr_en   = 1'b1;
            wr_data = r1[7:0];
            @(posedge clk);
            #1;
        end
        wr_en = 1'b0;
        build_expected(n);
        start     = 1'b1;
        start_cyc = cyc;
        seen      = 1'b0;
        first_cyc = 0;
        got_q.delete();
        forever begin
            @(posedge clk);
            #1;
            r1 = next_random();
            wr_en   = (r1[2:0] == 3'd0);    // Stray write while busy
            wr_data = r1[15:8];
            @(negedge clk);
            assert (!ready) else protocol_error($sformatf("frame %0d: ready high while sending", f));
            if (tx_en) begin
                if (!seen) first_cyc = cyc;
                seen = 1'b1;
                got_q.push_back(txd);
            end else if (seen) begin
                break;
            end
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
        end
        r1 = next_random();
        repeat (1 + r1 % 3) begin
            @(posedge clk);
            #1;
            assert (done) else protocol_error($sformatf("frame %0d: done fell while start high", f));
        end
        start = 1'b0;
        @(posedge clk);
        #1;
        assert (ready && !done)
            else protocol_error($sformatf("frame %0d: ready did not return after start fell", f));
        assert (first_cyc - start_cyc == 2)
            else value_error($sformatf("frame %0d start latency", f), 2, first_cyc - start_cyc);
        assert (got_q.size() == exp_q.size())
            else value_error($sformatf("frame %0d length", f), exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            assert (got_q[i] == exp_q[i])
                else value_error($sformatf("frame %0d %s byte %0d", f, section_of(i, n), i),
                                 exp_q[i], got_q[i]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        dst_addr  = '0;
        src_addr  = '0;
        eth_type  = '0;
        wr_en     = 1'b0;
        wr_data   = '0;
        start     = 1'b0;
        rng       = 32'ha2c4;
        cyc       = 0;
        err_value = 0;
        err_other = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) run_frame(f);
        repeat (5) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d protocol errors", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- eth_tx_sva.sv
`timescale 1ns/100ps

module eth_tx_sva import eth_tx_pkg::*; (
    input logic      clk,
    input logic      rst,
    input tx_state_t state,
    input logic      start,
    input logic      done,
    input logic      tx_en,
    input logic      fs_mac,
    input logic      mac_last
);

    // Wire stays quiet while the host prepares a frame
    no_tx_in_wait: assert property (@(posedge clk) disable iff (rst)
        (state == WAIT) |-> !tx_en)
        else $error("tx_en high while waiting for start");

    fs_mac_pulse: assert property (@(posedge clk) disable iff (rst)
        fs_mac |=> !fs_mac)
        else $error("fs_mac longer than one cycle");

    done_until_start_low: assert property (@(posedge clk) disable iff (rst)
        (done && start) |=> done)
        else $error("done dropped while start still high");

    last_in_work: assert property (@(posedge clk) disable iff (rst)
        mac_last |-> (state == WORK))
        else $error("mac_last outside the WORK state");

endmodule

bind frame_tx eth_tx_sva i_eth_tx_sva (
    .clk      (clk),
    .rst      (rst),
    .state    (state),
    .start    (start),
    .done     (done),
    .tx_en    (tx_en),
    .fs_mac   (mac.fs_mac),
    .mac_last (mac.mac_last)
);

//--- eth_tx_top.sv
`timescale 1ns/100ps

module eth_tx_top #(
    parameter int BUF_DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [47:0] dst_addr,
    input  logic [47:0] src_addr,
    input  logic [15:0] eth_type,
    input  logic        wr_en,
    input  logic [7:0]  wr_data,
    input  logic        start,
    output logic        ready,
    output logic        done,
    output logic [7:0]  txd,
    output logic        tx_en
);

    logic        crc_en;
    logic        crc_clr;
    logic [31:0] crc;

    eth_mac_if mac_if ();

    frame_tx i_frame_tx (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .done    (done),
        .ready   (ready),
        .crc_en  (crc_en),
        .crc_clr (crc_clr),
        .crc     (crc),
        .mac     (mac_if.tx),
        .txd     (txd),
        .tx_en   (tx_en)
    );

    // Host writes land only while the sequencer waits
    mac_framer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_mac_framer (
        .clk      (clk),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_ready (ready),
        .wr_data  (wr_data),
        .dst_addr (dst_addr),
        .src_addr (src_addr),
        .eth_type (eth_type),
        .mac      (mac_if.framer)
    );

    crc32_gen i_crc32_gen (
        .clk     (clk),
        .rst     (rst),
        .crc_clr (crc_clr),
        .crc_en  (crc_en),
        .data    (mac_if.mac_txd),
        .crc     (crc)
    );

endmodule

//--- frame_tx.sv
`timescale 1ns/100ps

module frame_tx import eth_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    output logic        done,
    output logic        ready,
    output logic        crc_en,
    output logic        crc_clr,
    input  logic [31:0] crc,
    eth_mac_if.tx       mac,
    output logic [7:0]  txd,
    output logic        tx_en
);

    tx_state_t state;
    tx_state_t next_state;

    assign ready      = (state == WAIT);
    assign done       = (state == DONE);
    assign crc_en     = (state == WORK);
    assign crc_clr    = (state == HD07);
    assign mac.fs_mac = (state == HD07);    // Framer starts with the SFD

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            IDLE: next_state = WAIT;
            WAIT: begin
                if (start && !mac.mac_busy) begin
                    next_state = HD00;
                end else begin
                    next_state = WAIT;
                end
            end
            HD00: next_state = HD01;
            HD01: next_state = HD02;
            HD02: next_state = HD03;
            HD03: next_state = HD04;
            HD04: next_state = HD05;
            HD05: next_state = HD06;
            HD06: next_state = HD07;
            HD07: next_state = WORK;
            WORK: begin
                if (mac.mac_last) begin
                    next_state = PT00;    // CRC has the last byte by then
                end else begin
                    next_state = WORK;
                end
            end
            PT00: next_state = PT01;
            PT01: next_state = PT02;
            PT02: next_state = PT03;
            PT03: next_state = DONE;
            DONE: begin
                if (!start) begin
                    next_state = WAIT;
                end else begin
                    next_state = DONE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // Wire byte lags the state by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            txd   <= 8'h00;
            tx_en <= 1'b0;
        end else begin
            case (state)
                HD00, HD01, HD02, HD03, HD04, HD05, HD06: begin
                    txd   <= PREAMBLE_BYTE;
                    tx_en <= 1'b1;
                end
                HD07: begin
                    txd   <= SFD_BYTE;
                    tx_en <= 1'b1;
                end
                WORK: begin
                    txd   <= mac.mac_txd;
                    tx_en <= 1'b1;
                end
                PT00: begin
                    txd   <= crc[31:24];
                    tx_en <= 1'b1;
                end
                PT01: begin
                    txd   <= crc[23:16];
                    tx_en <= 1'b1;
                end
                PT02: begin
                    txd   <= crc[15:8];
                    tx_en <= 1'b1;
                end
                PT03: begin
                    txd   <= crc[7:0];
                    tx_en <= 1'b1;
                end
                default: begin
                    txd   <= 8'h00;
                    tx_en <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- crc32_gen.sv
`timescale 1ns/100ps

module crc32_gen import eth_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        crc_clr,
    input  logic        crc_en,
    input  logic [7:0]  data,
    output logic [31:0] crc
);

    logic [31:0] crc_reg;
    logic [31:0] crc_inv;

    // One byte, LSB first, reflected polynomial
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        int          i;
        r = c;
        for (i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ CRC_POLY_REFL;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_reg <= CRC_INIT;
        end else if (crc_clr) begin
            crc_reg <= CRC_INIT;
        end else if (crc_en) begin
            crc_reg <= crc_byte(crc_reg, data);
        end
    end

    assign crc_inv = ~crc_reg;

    // Low register byte first on the wire, so it sits on top
    assign crc = {crc_inv[7:0], crc_inv[15:8], crc_inv[23:16], crc_inv[31:24]};

endmodule

//--- mac_framer.sv
`timescale 1ns/100ps

module mac_framer import eth_tx_pkg::*; #(
    parameter int BUF_DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic        wr_ready,
    input  logic [7:0]  wr_data,
    input  logic [47:0] dst_addr,
    input  logic [47:0] src_addr,
    input  logic [15:0] eth_type,
    eth_mac_if.framer   mac
);

    localparam int ADDR_W = $clog2(BUF_DEPTH);
    localparam int LEN_W  = $clog2(BUF_DEPTH + 1);
    localparam int HDR_W  = HDR_BYTES * 8;

    logic [7:0]       mem [BUF_DEPTH];
    logic [LEN_W-1:0] count;    // Bytes held in the buffer
    logic [LEN_W-1:0] pos;      // Data plus pad bytes sent
    logic [3:0]       hcnt;
    logic [HDR_W-1:0] hdr;
    mac_field_t       field;
    logic             wr_ok;
    logic             in_hdr;
    logic             data_end;
    logic             past_min;
    logic             last;

    assign wr_ok    = wr_en && wr_ready && (count != LEN_W'(BUF_DEPTH));
    assign in_hdr   = (field == F_DST) || (field == F_SRC) || (field == F_TYPE);
    assign data_end = (pos == count - LEN_W'(1));
    assign past_min = (pos >= LEN_W'(MIN_PAYLOAD - 1));

    assign last = ((field == F_DATA) && data_end && past_min) ||
                  ((field == F_PAD) && past_min);

    assign mac.mac_last = last;
    assign mac.mac_busy = mac.fs_mac || (field != F_IDLE);

    always_comb begin
        case (field)
            F_DST, F_SRC, F_TYPE: mac.mac_txd = hdr[HDR_W-1 -: 8];
            F_DATA:               mac.mac_txd = mem[pos[ADDR_W-1:0]];
            default:              mac.mac_txd = 8'h00;    // Pad and idle
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[count[ADDR_W-1:0]] <= wr_data;
        end
    end

    // Header goes out MSB first, one byte per shift
    always_ff @(posedge clk) begin
        if ((field == F_IDLE) && mac.fs_mac) begin
            hdr <= {dst_addr, src_addr, eth_type};
        end else if (in_hdr) begin
            hdr <= hdr << 8;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (last) begin
            count <= '0;    // Frame finished, buffer free
        end else if (wr_ok) begin
            count <= count + LEN_W'(1);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            field <= F_IDLE;
            hcnt  <= '0;
            pos   <= '0;
        end else begin
            case (field)
                F_IDLE: begin
                    if (mac.fs_mac) begin
                        field <= F_DST;
                        hcnt  <= '0;
                        pos   <= '0;
                    end
                end
                F_DST: begin
                    hcnt <= hcnt + 4'd1;
                    if (hcnt == 4'd5) begin
                        field <= F_SRC;
                    end
                end
                F_SRC: begin
                    hcnt <= hcnt + 4'd1;
                    if (hcnt == 4'd11) begin
                        field <= F_TYPE;
                    end
                end
                F_TYPE: begin
                    hcnt <= hcnt + 4'd1;
                    if (hcnt == 4'(HDR_BYTES - 1)) begin
                        field <= (count != '0) ? F_DATA : F_PAD;    // Empty payload pads only
                    end
                end
                F_DATA: begin
                    pos <= pos + LEN_W'(1);
                    if (data_end) begin
                        field <= past_min ? F_IDLE : F_PAD;
                    end
                end
                F_PAD: begin
                    pos <= pos + LEN_W'(1);
                    if (past_min) begin
                        field <= F_IDLE;
                    end
                end
                default: field <= F_IDLE;
            endcase
        end
    end

endmodule

//--- eth_mac_if.sv
`timescale 1ns/100ps

interface eth_mac_if;

    logic       fs_mac;      // Start pulse to the framer
    logic [7:0] mac_txd;
    logic       mac_last;    // Final data or pad byte
    logic       mac_busy;

    modport tx (
        output fs_mac,
        input  mac_txd,
        input  mac_last,
        input  mac_busy
    );

    modport framer (
        input  fs_mac,
        output mac_txd,
        output mac_last,
        output mac_busy
    );

endinterface

//--- eth_tx_pkg.sv
package eth_tx_pkg;

    typedef enum logic [3:0] {
        IDLE,
        WAIT,
        HD00,
        HD01,
        HD02,
        HD03,
        HD04,
        HD05,
        HD06,
        HD07,    // SFD slot
        WORK,    // Framer bytes on the wire
        PT00,
        PT01,
        PT02,
        PT03,
        DONE
    } tx_state_t;

    typedef enum logic [2:0] {
        F_IDLE,
        F_DST,
        F_SRC,
        F_TYPE,
        F_DATA,
        F_PAD
    } mac_field_t;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;

    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;    // 0x04C11DB7 bit-reversed
    localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;

    localparam int MIN_PAYLOAD = 46;
    localparam int HDR_BYTES   = 14;    // DA + SA + EtherType

endpackage
